//--- edma.f
+incdir+src
src/edma_pkg.sv
src/edma_if.sv
src/edma_regs.sv
src/edma_ctrl.sv
src/edma_datapath.sv
src/edma_mem.sv
src/edma_top.sv
verif/edma_tb.sv

//--- run.sh
#!/bin/sh
# build the dma engine testbench with verilator, run it, look for the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  -f edma.f --top-module edma_tb -o edma_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

out=$(./obj_dir/edma_sim 2>&1)
rc=$?
printf '%s\n' "$out"
if [ $rc -ne 0 ]; then
  echo "simulation exited with status $rc"
  exit 1
fi

if printf '%s\n' "$out" | grep -qx '>>> PASS'; then
  exit 0
fi
echo "pass line missing from simulation output"
exit 1

//--- verif/edma_tb.sv
/*
 * dma engine testbench
 * clock and reset, apb tasks, lcg memory fill,
 * transfer table with reference model and memory readback
 */
`default_nettype none
`include "edma_params.svh"

module edma_tb;
  import edma_pkg::*;

  localparam int         NUM_CASES = 6;
  localparam int         APB_LIMIT = 2000;   // cycles, per apb wait
  localparam int         IRQ_LIMIT = 2000;
  localparam logic [7:0] DESC_BASE = 8'hE0;  // descriptor area, 4 words per row

  typedef struct packed {
    logic [7:0]  src;
    logic [7:0]  dst;
    logic [15:0] inner;    // words per row minus one
    logic [15:0] outer;    // rows minus one
    logic [7:0]  stride;   // gap between rows, words
    logic        chain;    // next row runs in the same transfer
    logic        manual;
  } xfer_t;

  logic                   clk;
  logic                   nreset;
  logic [`EDMA_MEM_SEL:0] paddr;
  logic                   psel;
  logic                   penable;
  logic                   pwrite;
  logic [`EDMA_DW-1:0]    pwdata;
  wire  [`EDMA_DW-1:0]    prdata;
  wire                    pready;
  wire                    pslverr;
  wire                    irq;

  logic [`EDMA_DW-1:0] ref_mem [`EDMA_MEM_DEPTH];  // reference memory
  xfer_t               xfer_tab [NUM_CASES];
  logic [31:0]         lcg_state;

  edma_top dut0 (
    .clk     (clk),
    .nreset  (nreset),
    .paddr   (paddr),
    .psel    (psel),
    .penable (penable),
    .pwrite  (pwrite),
    .pwdata  (pwdata),
    .prdata  (prdata),
    .pready  (pready),
    .pslverr (pslverr),
    .irq     (irq)
  );

  always #50 clk = ~clk;  // period 100

  // ##########################################################################
  // helpers

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic logic [`EDMA_MEM_SEL:0] reg_paddr(input reg_addr_e r);
    return {{(`EDMA_MEM_SEL - 4){1'b0}}, r, 2'b00};
  endfunction

  function automatic logic [`EDMA_MEM_SEL:0] mem_paddr(input logic [7:0] a);
    return {1'b1, {(`EDMA_MEM_SEL - `EDMA_AW - 2){1'b0}}, a, 2'b00};  // window bit set
  endfunction

  function automatic logic [31:0] status_word(input dma_state_e st, input logic done);
    logic [31:0] w;
    w            = '0;
    w[2:0]       = st;
    w[STAT_DONE] = done;
    return w;
  endfunction

  function automatic logic [7:0] desc_addr(input int k);
    return DESC_BASE + 8'(4 * k);
  endfunction

  function automatic logic [31:0] descr_w0(input xfer_t x, input logic [7:0] next);
    return {8'h00, next, x.stride, 7'd0, x.chain};
  endfunction

  // word address of the last word a row set writes
  function automatic logic [7:0] last_dst(input xfer_t x);
    logic [7:0] pitch;
    pitch = 8'(x.inner) + 8'd1 + x.stride;
    return x.dst + 8'(x.outer) * pitch + 8'(x.inner);
  endfunction

  task automatic stop_run(input string msg);
    $display("%s", msg);
    $display(">>> FAIL");
    $fatal(1);
  endtask

  task automatic check_eq(input string name, input logic [31:0] exp, input logic [31:0] got);
    assert (got === exp) else begin
      $display("[FAIL] time %0t: %s expected %h, got %h", $time, name, exp, got);
      stop_run("value mismatch, stopping");
    end
  endtask

  // ##########################################################################
  // apb master

  task automatic apb_xfer(input logic [`EDMA_MEM_SEL:0] a, input logic wr,
                          input logic [31:0] wd, output logic [31:0] rd);
    int n;
    @(posedge clk);
    #10;
    paddr   = a;       // setup phase
    pwrite  = wr;
    pwdata  = wd;
    psel    = 1'b1;
    penable = 1'b0;
    @(posedge clk);
    #10;
    penable = 1'b1;    // access phase
    n = 0;
    @(negedge clk);
    while (pready !== 1'b1) begin
      n++;
      if (n > APB_LIMIT)
        stop_run("apb transfer timed out, pready never came");
      @(negedge clk);
    end
    rd = prdata;       // stable mid cycle
    check_eq("pslverr", 32'd0, 32'(pslverr));
    @(posedge clk);
    #10;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  task automatic apb_write(input logic [`EDMA_MEM_SEL:0] a, input logic [31:0] d);
    logic [31:0] unused_rd;
    apb_xfer(a, 1'b1, d, unused_rd);
  endtask

  task automatic apb_read(input logic [`EDMA_MEM_SEL:0] a, output logic [31:0] d);
    apb_xfer(a, 1'b0, 32'd0, d);
  endtask

  task automatic wait_irq();
    int n;
    n = 0;
    while (irq !== 1'b1) begin
      @(negedge clk);
      n++;
      if (n > IRQ_LIMIT)
        stop_run("dma engine never finished, irq stayed low");
    end
  endtask

  // ##########################################################################
  // memory and reference model

  task automatic write_mem(input logic [7:0] a, input logic [31:0] d);
    ref_mem[a] = d;
    apb_write(mem_paddr(a), d);
  endtask

  task automatic put_descr(input logic [7:0] base, input xfer_t x, input logic [7:0] next);
    write_mem(base, descr_w0(x, next));
    write_mem(base + 8'd1, {x.outer, x.inner});
    write_mem(base + 8'd2, {24'd0, x.src});
    write_mem(base + 8'd3, {24'd0, x.dst});
  endtask

  // row r sits at base + r * (inner + 1 + stride), both sides
  task automatic model_copy(input xfer_t x);
    logic [7:0] pitch;
    logic [7:0] s;
    logic [7:0] d;
    pitch = 8'(x.inner) + 8'd1 + x.stride;
    for (int r = 0; r <= int'(x.outer); r++) begin
      s = x.src + 8'(r) * pitch;
      d = x.dst + 8'(r) * pitch;
      for (int c = 0; c <= int'(x.inner); c++) begin
        ref_mem[d] = ref_mem[s];
        s = s + 8'd1;
        d = d + 8'd1;
      end
    end
  endtask

  task automatic compare_mem();
    logic [31:0] data;
    for (int a = 0; a < `EDMA_MEM_DEPTH; a++) begin
      apb_read(mem_paddr(8'(a)), data);
      check_eq($sformatf("mem[%0d]", a), ref_mem[a], data);
    end
  endtask

  // src, dst, inner, outer, stride, chain, manual
  task automatic load_table();
    xfer_tab[0] = '{8'h00, 8'h80, 16'd7, 16'd0, 8'd0, 1'b0, 1'b0};  // 1d
    xfer_tab[1] = '{8'h10, 8'h90, 16'd3, 16'd2, 8'd2, 1'b0, 1'b0};  // 2d, stride
    xfer_tab[2] = '{8'h20, 8'hA0, 16'd4, 16'd0, 8'd0, 1'b1, 1'b0};  // chain head
    xfer_tab[3] = '{8'h30, 8'hA8, 16'd1, 16'd3, 8'd1, 1'b0, 1'b0};  // chain tail
    xfer_tab[4] = '{8'h40, 8'hC0, 16'd5, 16'd1, 8'd3, 1'b0, 1'b1};  // manual
    xfer_tab[5] = '{8'h50, 8'hD0, 16'd9, 16'd0, 8'd0, 1'b0, 1'b0};
  endtask

  // ##########################################################################
  // one transfer, rows first..last

  task automatic run_transfer(input int first, input int last);
    xfer_t       x;
    xfer_t       poison;
    logic [7:0]  tail;
    logic [31:0] data;
    x = xfer_tab[first];
    if (x.manual) begin
      // decoy descriptor in memory, a fetch would copy the wrong block
      poison = '{src: 8'h60, dst: 8'h68, inner: 16'd3, outer: 16'd0,
                 stride: 8'd0, chain: 1'b0, manual: 1'b0};
      put_descr(desc_addr(first), poison, 8'h00);
      apb_write(reg_paddr(REG_NEXT), 32'(desc_addr(first)));
      apb_write(reg_paddr(REG_DCFG), descr_w0(x, 8'h00));
      apb_write(reg_paddr(REG_DCOUNT), {x.outer, x.inner});
      apb_write(reg_paddr(REG_DSRC), {24'd0, x.src});
      apb_write(reg_paddr(REG_DDST), {24'd0, x.dst});
    end else begin
      for (int k = first; k <= last; k++)
        put_descr(desc_addr(k), xfer_tab[k], desc_addr(k + 1));
      apb_write(reg_paddr(REG_NEXT), 32'(desc_addr(first)));
    end
    for (int k = first; k <= last; k++)
      model_copy(xfer_tab[k]);
    tail = last_dst(xfer_tab[last]);

    apb_write(reg_paddr(REG_CTRL), {30'd0, x.manual, 1'b1});  // enable rises
    apb_read(mem_paddr(tail), data);                          // held off while busy
    check_eq("prdata busy read", ref_mem[tail], data);
    wait_irq();
    apb_read(reg_paddr(REG_STATUS), data);
    check_eq("status at done", status_word(DONE, 1'b1), data);

    apb_write(reg_paddr(REG_STATUS), 32'd1 << STAT_DONE);     // clear done
    check_eq("irq after clear", 32'd0, 32'(irq));
    apb_write(reg_paddr(REG_CTRL), 32'd0);
    apb_read(reg_paddr(REG_STATUS), data);
    check_eq("status after disable", status_word(IDLE, 1'b0), data);
    compare_mem();
  endtask

  // ##########################################################################
  // main sequence

  initial begin
    logic [31:0] data;
    int          first;
    int          last;
    lcg_state = 32'h63b4f15d;
    clk       = 1'b0;
    nreset    = 1'b0;
    paddr     = '0;
    psel      = 1'b0;
    penable   = 1'b0;
    pwrite    = 1'b0;
    pwdata    = '0;
    load_table();
    repeat (3) @(posedge clk);
    #10;
    nreset = 1'b1;

    // quiet after reset
    check_eq("pready", 32'd0, 32'(pready));
    check_eq("irq", 32'd0, 32'(irq));
    apb_read(reg_paddr(REG_STATUS), data);
    check_eq("status after reset", status_word(IDLE, 1'b0), data);

    for (int a = 0; a < `EDMA_MEM_DEPTH; a++) begin
      lcg_state = lcg_next(lcg_state);
      write_mem(8'(a), lcg_state);
    end
    compare_mem();

    first = 0;
    while (first < NUM_CASES) begin
      last = first;
      while (xfer_tab[last].chain && last + 1 < NUM_CASES)
        last++;                                  // collect the chain
      run_transfer(first, last);
      first = last + 1;
    end

    $display(">>> PASS");
    $finish;
  end

endmodule

`default_nettype wire

//--- src/edma_top.sv
/*
 * dma engine top level
 * apb slave, sequencer, datapath and memory
 */
`default_nettype none
`include "edma_params.svh"

module edma_top (
  input  wire                   clk,
  input  wire                   nreset,
  input  wire [`EDMA_MEM_SEL:0] paddr,
  input  wire                   psel,
  input  wire                   penable,
  input  wire                   pwrite,
  input  wire [`EDMA_DW-1:0]    pwdata,
  output wire [`EDMA_DW-1:0]    prdata,
  output wire                   pready,
  output wire                   pslverr,
  output wire                   irq
);
  edma_cfg_if cfg ();
  edma_mem_if dp_rd ();     // datapath reads, into the fetch mux
  edma_mem_if rd_port ();   // muxed read port
  edma_mem_if wr_port ();
  edma_mem_if mem_host ();  // apb memory window

  wire                inner_zero;
  wire                outer_zero;
  wire                chain;
  wire [`EDMA_AW-1:0] next_ptr;

  edma_regs regs0 (
    .clk      (clk),
    .nreset   (nreset),
    .paddr    (paddr),
    .psel     (psel),
    .penable  (penable),
    .pwrite   (pwrite),
    .pwdata   (pwdata),
    .prdata   (prdata),
    .pready   (pready),
    .pslverr  (pslverr),
    .irq      (irq),
    .cfg      (cfg.regs),
    .mem_host (mem_host.host)
  );

  edma_ctrl ctrl0 (
    .clk        (clk),
    .nreset     (nreset),
    .cfg        (cfg.ctrl),
    .rd_port    (rd_port.master),
    .dp_rd      (dp_rd.slave),
    .inner_zero (inner_zero),
    .outer_zero (outer_zero),
    .chain      (chain),
    .next_ptr   (next_ptr)
  );

  edma_datapath dp0 (
    .clk        (clk),
    .nreset     (nreset),
    .cfg        (cfg.dp),
    .rd_req     (dp_rd.master),
    .wr_port    (wr_port.master),
    .rd_data    (rd_port.rdata),
    .inner_zero (inner_zero),
    .outer_zero (outer_zero),
    .chain      (chain),
    .next_ptr   (next_ptr)
  );

  edma_mem mem0 (
    .clk     (clk),
    .rd_port (rd_port.slave),
    .wr_port (wr_port.slave),
    .host    (mem_host.slave)
  );

endmodule

`default_nettype wire

//--- src/edma_mem.sv
/*
 * word memory, one read port and one write port
 * registered read, host shares both ports behind the engine
 */
`default_nettype none
`include "edma_params.svh"

module edma_mem (
  input wire        clk,
  edma_mem_if.slave rd_port,
  edma_mem_if.slave wr_port,
  edma_mem_if.slave host
);
  logic [`EDMA_DW-1:0] mem [`EDMA_MEM_DEPTH];
  logic [`EDMA_DW-1:0] rd_q;
  logic                host_wr;   // host write granted
  logic                host_rd;   // host read granted

  // engine always first, host reads also wait out a pending engine write
  assign host_wr = host.req & host.we & ~wr_port.req;
  assign host_rd = host.req & ~host.we & ~rd_port.req & ~wr_port.req;

  always_ff @(posedge clk) begin
    if (wr_port.req && wr_port.we)
      mem[wr_port.addr] <= wr_port.wdata;
    else if (host_wr)
      mem[host.addr] <= host.wdata;
    if (rd_port.req)
      rd_q <= mem[rd_port.addr];
    else if (host_rd)
      rd_q <= mem[host.addr];                                // held otherwise
  end

  assign rd_port.rdata = rd_q;
  assign wr_port.rdata = rd_q;
  assign host.rdata    = rd_q;

  assign rd_port.gnt = rd_port.req;
  assign wr_port.gnt = wr_port.req;
  assign host.gnt    = host_wr | host_rd;

endmodule

`default_nettype wire

//--- src/edma_datapath.sv
/*
 * dma datapath
 * descriptor capture, pointers and counters,
 * read stage then write stage copy pipeline
 */
`default_nettype none
`include "edma_params.svh"

module edma_datapath (
  input  wire                 clk,
  input  wire                 nreset,
  edma_cfg_if.dp              cfg,
  edma_mem_if.master          rd_req,
  edma_mem_if.master          wr_port,
  input  wire [`EDMA_DW-1:0]  rd_data,
  output logic                inner_zero,
  output logic                outer_zero,
  output logic                chain,
  output logic [`EDMA_AW-1:0] next_ptr
);
  import edma_pkg::*;

  dma_state_e          st_q;       // state one cycle back
  logic                fresh_q;    // st_q had just been entered
  logic                cap;        // rd_data holds a fetched word
  logic                load_man;   // manual start, all words at once
  logic                ld0;
  logic                ld1;
  logic                ld2;
  logic                ld3;
  logic [`EDMA_DW-1:0] w0;
  logic [`EDMA_DW-1:0] w1;
  logic [`EDMA_DW-1:0] w2;
  logic [`EDMA_DW-1:0] w3;
  logic [`EDMA_AW-1:0] stride;
  logic [CNT_W-1:0]    inner_ld;   // row length reload
  logic [CNT_W-1:0]    inner_cnt;
  logic [CNT_W-1:0]    outer_cnt;
  logic [`EDMA_AW-1:0] src_ptr;
  logic [`EDMA_AW-1:0] dst_ptr;
  logic                rd_go;
  logic                wr_vld_q;   // write stage
  logic [`EDMA_AW-1:0] wr_addr_q;

  // fetched word lands one cycle after its FETCH state, once
  assign cap      = fresh_q & (st_q inside {FETCH0, FETCH1, FETCH2, FETCH3});
  assign load_man = cfg.start & cfg.manual & (cfg.state == IDLE);

  assign ld0 = load_man | (cap & (st_q == FETCH0));
  assign ld1 = load_man | (cap & (st_q == FETCH1));
  assign ld2 = load_man | (cap & (st_q == FETCH2));
  assign ld3 = load_man | (cap & (st_q == FETCH3));
  assign w0  = load_man ? cfg.dcfg   : rd_data;
  assign w1  = load_man ? cfg.dcount : rd_data;
  assign w2  = load_man ? cfg.dsrc   : rd_data;
  assign w3  = load_man ? cfg.ddst   : rd_data;

  assign rd_go = (cfg.state == INNER);                       // one read per cycle

  always_ff @(posedge clk or negedge nreset) begin
    if (!nreset) begin
      st_q     <= IDLE;
      fresh_q  <= 1'b0;
      wr_vld_q <= 1'b0;
    end else begin
      st_q     <= cfg.state;
      fresh_q  <= (cfg.state != st_q);
      wr_vld_q <= rd_go;
    end
  end

  // ##########################################################################
  // descriptor, pointers, counters

  always_ff @(posedge clk) begin
    if (ld0) begin
      chain    <= w0[D0_CHAIN];
      stride   <= w0[D0_STRIDE_LSB +: `EDMA_AW];
      next_ptr <= w0[D0_NEXT_LSB +: `EDMA_AW];
    end
    if (ld1) begin
      inner_ld  <= w1[D1_INNER_LSB +: CNT_W];
      inner_cnt <= w1[D1_INNER_LSB +: CNT_W];
      outer_cnt <= w1[D1_OUTER_LSB +: CNT_W];
    end
    if (ld2)
      src_ptr <= w2[`EDMA_AW-1:0];
    if (ld3)
      dst_ptr <= w3[`EDMA_AW-1:0];
    if (rd_go) begin
      src_ptr   <= src_ptr + 1'b1;
      dst_ptr   <= dst_ptr + 1'b1;
      wr_addr_q <= dst_ptr;                                  // travels with the read
      if (!inner_zero)
        inner_cnt <= inner_cnt - 1'b1;
    end
    if (cfg.state == OUTER) begin
      outer_cnt <= outer_cnt - 1'b1;
      inner_cnt <= inner_ld;
      src_ptr   <= src_ptr + stride;                         // skip the gap
      dst_ptr   <= dst_ptr + stride;
    end
  end

  assign inner_zero = (inner_cnt == '0);
  assign outer_zero = (outer_cnt == '0);

  // read stage
  assign rd_req.req   = rd_go;
  assign rd_req.we    = 1'b0;
  assign rd_req.addr  = src_ptr;
  assign rd_req.wdata = '0;

  // write stage, data straight from the memory read register
  assign wr_port.req   = wr_vld_q;
  assign wr_port.we    = 1'b1;
  assign wr_port.addr  = wr_addr_q;
  assign wr_port.wdata = rd_data;

  a_wr_after_rd: assert property (@(posedge clk) disable iff (!nreset)
    wr_port.req |-> $past(rd_req.req));

endmodule

`default_nettype wire

//--- src/edma_ctrl.sv
/*
 * dma sequencer
 * state machine, descriptor fetch addresses, read port mux
 */
`default_nettype none
`include "edma_params.svh"

module edma_ctrl (
  input  wire                clk,
  input  wire                nreset,
  edma_cfg_if.ctrl           cfg,
  edma_mem_if.master         rd_port,
  edma_mem_if.slave          dp_rd,
  input  wire                inner_zero,
  input  wire                outer_zero,
  input  wire                chain,
  input  wire [`EDMA_AW-1:0] next_ptr
);
  import edma_pkg::*;

  dma_state_e          state;
  logic                hold_q;     // capture cycle of word 3
  logic                done_q;     // was in DONE last cycle
  logic [`EDMA_AW-1:0] descr_q;    // current descriptor base
  logic                fetch_req;
  logic [1:0]          fetch_idx;  // descriptor word
  logic                stop;       // nothing to chain to

  assign stop = ~chain | cfg.manual;                         // manual never chains

  // ##########################################################################
  // state machine

  always_ff @(posedge clk or negedge nreset) begin
    if (!nreset) begin
      state   <= IDLE;
      hold_q  <= 1'b0;
      done_q  <= 1'b0;
      descr_q <= '0;
    end else begin
      done_q <= (state == DONE);
      hold_q <= (state == FETCH3) & ~hold_q;
      case (state)
        IDLE: begin
          if (cfg.start) begin
            state   <= cfg.manual ? INNER : FETCH0;          // manual skips fetch
            descr_q <= cfg.next_descr;
          end
        end
        FETCH0: state <= FETCH1;
        FETCH1: state <= FETCH2;
        FETCH2: state <= FETCH3;
        FETCH3: begin
          if (hold_q)
            state <= INNER;                                  // word 3 captured
        end
        INNER: begin
          if (inner_zero)                                    // last read of the row
            state <= outer_zero ? DONE : OUTER;
        end
        OUTER: state <= INNER;                               // stride, reload
        DONE: begin
          if (!stop) begin
            state   <= FETCH0;
            descr_q <= next_ptr;
          end else if (!cfg.enable) begin
            state <= IDLE;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  assign cfg.state      = state;
  assign cfg.done_pulse = (state == DONE) & ~done_q & stop;  // once per stop

  // ##########################################################################
  // descriptor fetch and read mux

  always_comb begin
    fetch_req = 1'b1;
    fetch_idx = 2'd0;
    case (state)
      FETCH0: fetch_idx = 2'd0;
      FETCH1: fetch_idx = 2'd1;
      FETCH2: fetch_idx = 2'd2;
      FETCH3: begin
        fetch_idx = 2'd3;
        fetch_req = ~hold_q;                                 // no read in hold
      end
      default: fetch_req = 1'b0;
    endcase
  end

  assign rd_port.req   = fetch_req | dp_rd.req;
  assign rd_port.we    = ~fetch_req & dp_rd.we;
  assign rd_port.addr  = fetch_req ? descr_q + `EDMA_AW'(fetch_idx) : dp_rd.addr;
  assign rd_port.wdata = dp_rd.wdata;
  assign dp_rd.rdata   = rd_port.rdata;
  assign dp_rd.gnt     = dp_rd.req & ~fetch_req;

  a_state_known: assert property (@(posedge clk) disable iff (!nreset)
    !$isunknown(state));

endmodule

`default_nettype wire

//--- src/edma_regs.sv
/*
 * apb slave of the dma engine
 * control, pointer, status and manual descriptor registers,
 * memory window, sticky done flag and interrupt
 */
`default_nettype none
`include "edma_params.svh"

module edma_regs (
  input  wire                   clk,
  input  wire                   nreset,
  input  wire [`EDMA_MEM_SEL:0] paddr,
  input  wire                   psel,
  input  wire                   penable,
  input  wire                   pwrite,
  input  wire [`EDMA_DW-1:0]    pwdata,
  output logic [`EDMA_DW-1:0]   prdata,
  output logic                  pready,
  output logic                  pslverr,
  output logic                  irq,
  edma_cfg_if.regs              cfg,
  edma_mem_if.host              mem_host
);
  import edma_pkg::*;

  logic                enable;
  logic                manual;
  logic                en_q;       // enable, one cycle late
  logic                done;       // sticky
  logic [`EDMA_AW-1:0] next_descr;
  logic [`EDMA_DW-1:0] dcfg;
  logic [`EDMA_DW-1:0] dcount;
  logic [`EDMA_DW-1:0] dsrc;
  logic [`EDMA_DW-1:0] ddst;
  logic                mem_sel;    // paddr hits memory window
  logic                reg_wr;
  logic                mem_ack;    // window access took effect last cycle
  logic [`EDMA_DW-1:0] reg_rdata;
  reg_addr_e           reg_addr;

  assign mem_sel  = paddr[`EDMA_MEM_SEL];
  assign reg_addr = reg_addr_e'(paddr[4:2]);
  assign reg_wr   = psel & penable & pwrite & ~mem_sel;

  // ##########################################################################
  // control registers

  always_ff @(posedge clk or negedge nreset) begin
    if (!nreset) begin
      enable     <= 1'b0;
      manual     <= 1'b0;
      en_q       <= 1'b0;
      done       <= 1'b0;
      next_descr <= '0;
    end else begin
      en_q <= enable;
      if (reg_wr && reg_addr == REG_CTRL) begin
        enable <= pwdata[CTRL_EN];
        manual <= pwdata[CTRL_MANUAL];
      end
      if (reg_wr && reg_addr == REG_NEXT)
        next_descr <= pwdata[`EDMA_AW-1:0];
      if (cfg.done_pulse)                                    // set wins over clear
        done <= 1'b1;
      else if (reg_wr && reg_addr == REG_STATUS && pwdata[STAT_DONE])
        done <= 1'b0;
    end
  end

  // manual descriptor words
  always_ff @(posedge clk) begin
    if (reg_wr) begin
      case (reg_addr)
        REG_DCFG:   dcfg   <= pwdata;
        REG_DCOUNT: dcount <= pwdata;
        REG_DSRC:   dsrc   <= pwdata;
        REG_DDST:   ddst   <= pwdata;
        default: ;
      endcase
    end
  end

  always_comb begin
    reg_rdata = '0;                                          // unmapped reads 0
    case (reg_addr)
      REG_CTRL: begin
        reg_rdata[CTRL_EN]     = enable;
        reg_rdata[CTRL_MANUAL] = manual;
      end
      REG_NEXT:   reg_rdata[`EDMA_AW-1:0] = next_descr;
      REG_STATUS: begin
        reg_rdata[2:0]       = cfg.state;
        reg_rdata[STAT_DONE] = done;
      end
      REG_DCFG:   reg_rdata = dcfg;
      REG_DCOUNT: reg_rdata = dcount;
      REG_DSRC:   reg_rdata = dsrc;
      REG_DDST:   reg_rdata = ddst;
      default: ;
    endcase
  end

  // ##########################################################################
  // memory window

  // reads only while the engine leaves the read port alone
  assign mem_host.req   = psel & penable & mem_sel & ~mem_ack &
                          (pwrite | (cfg.state == IDLE) | (cfg.state == DONE));
  assign mem_host.we    = pwrite;
  assign mem_host.addr  = paddr[`EDMA_AW+1:2];               // byte to word
  assign mem_host.wdata = pwdata;

  always_ff @(posedge clk or negedge nreset) begin
    if (!nreset)
      mem_ack <= 1'b0;
    else
      mem_ack <= mem_host.req & mem_host.gnt;
  end

  assign pready  = (psel & penable & ~mem_sel) | mem_ack;    // regs never wait
  assign prdata  = mem_sel ? mem_host.rdata : reg_rdata;
  assign pslverr = 1'b0;
  assign irq     = done;

  assign cfg.enable     = enable;
  assign cfg.manual     = manual;
  assign cfg.next_descr = next_descr;
  assign cfg.dcfg       = dcfg;
  assign cfg.dcount     = dcount;
  assign cfg.dsrc       = dsrc;
  assign cfg.ddst       = ddst;
  assign cfg.start      = enable & ~en_q;                    // rising edge

  // the delayed window ack must still fall inside the transfer
  a_pready_psel: assert property (@(posedge clk) disable iff (!nreset)
    pready |-> psel);

endmodule

`default_nettype wire

//--- src/edma_if.sv
/*
 * edma_cfg_if  configuration and status between the stages
 * edma_mem_if  one memory port with registered read data
 */
`default_nettype none
`include "edma_params.svh"

interface edma_cfg_if;
  import edma_pkg::*;

  logic                enable;      // ctrl bits
  logic                manual;
  logic [`EDMA_AW-1:0] next_descr;  // first descriptor word address
  logic [`EDMA_DW-1:0] dcfg;        // manual descriptor, words 0..3
  logic [`EDMA_DW-1:0] dcount;
  logic [`EDMA_DW-1:0] dsrc;
  logic [`EDMA_DW-1:0] ddst;
  logic                start;       // one cycle, enable rose
  dma_state_e          state;
  logic                done_pulse;  // last descriptor finished

  modport regs (output enable, manual, next_descr, dcfg, dcount, dsrc, ddst, start,
                input  state, done_pulse);
  modport ctrl (input  enable, manual, next_descr, start,
                output state, done_pulse);
  modport dp   (input  manual, dcfg, dcount, dsrc, ddst, start, state);
endinterface

interface edma_mem_if;
  logic                req;
  logic                we;
  logic [`EDMA_AW-1:0] addr;   // word address
  logic [`EDMA_DW-1:0] wdata;
  logic [`EDMA_DW-1:0] rdata;  // one cycle after a read req
  logic                gnt;    // request taken this cycle

  modport master (output req, we, addr, wdata, input rdata);
  modport host   (output req, we, addr, wdata, input rdata, gnt);
  modport slave  (input  req, we, addr, wdata, output rdata, gnt);
endinterface

`default_nettype wire

//--- src/edma_pkg.sv
/*
 * shared dma types
 * sequencer states, register offsets, ctrl/status bits, descriptor fields
 */
`default_nettype none

package edma_pkg;

  typedef enum logic [2:0] {
    IDLE, FETCH0, FETCH1, FETCH2, FETCH3, INNER, OUTER, DONE
  } dma_state_e;

  // register word offsets, paddr[4:2]
  typedef enum logic [2:0] {
    REG_CTRL   = 3'd0,  // enable, manual
    REG_NEXT   = 3'd1,  // next descriptor address
    REG_STATUS = 3'd2,  // state, done flag (write 1 clears)
    REG_DCFG   = 3'd3,  // manual descriptor words 0..3
    REG_DCOUNT = 3'd4,
    REG_DSRC   = 3'd5,
    REG_DDST   = 3'd6
  } reg_addr_e;

  localparam int CTRL_EN     = 0;
  localparam int CTRL_MANUAL = 1;
  localparam int STAT_DONE   = 8;     // state sits in [2:0]

  // descriptor word 0
  localparam int D0_CHAIN      = 0;
  localparam int D0_STRIDE_LSB = 8;   // 15..8, words
  localparam int D0_NEXT_LSB   = 16;  // 31..16
  // descriptor word 1
  localparam int D1_INNER_LSB  = 0;   // 15..0
  localparam int D1_OUTER_LSB  = 16;  // 31..16
  localparam int CNT_W         = 16;  // both counts

endpackage

`default_nettype wire

//--- src/edma_params.svh
/*
 * dma engine sizing macros
 * data width, memory size, word address width, apb memory-window bit
 */
`ifndef EDMA_PARAMS_SVH
`define EDMA_PARAMS_SVH

// data path
`define EDMA_DW        32   // data and register width

// word memory
`define EDMA_MEM_DEPTH 256  // words
`define EDMA_AW        8    // word address, log2 of depth

// apb decode
`define EDMA_MEM_SEL   12   // paddr bit, set for the memory window

`endif
